// File: list.f
common/reg_stage_pkg.sv
hdl/instr_decoder.sv
hdl/misc_pipe.sv
regfile/regfile.sv
hdl/reg_stage_top.sv
verification/tb_reg_stage.sv

// File: Bender.yml
package:
  name: reg_stage

sources:
  - common/reg_stage_pkg.sv
  - hdl/instr_decoder.sv
  - hdl/misc_pipe.sv
  - regfile/regfile.sv
  - hdl/reg_stage_top.sv
  - target: simulation
    files:
      - verification/tb_reg_stage.sv

// File: verification/tb_reg_stage.sv
module tb_reg_stage;

	localparam int data_width    = 32;
	localparam int clock_period  = 4;
	localparam int test_cycles   = 80; // Upper bound of cycles over all tests
	localparam int margin_cycles = 40;

	logic                    clock = 1'b0;
	logic                    reset;
	reg_stage_pkg::instr_t   instr;
	logic                    instr_valid;
	logic                    enable_reg_fetch;
	logic                    enable_reg_write;
	reg_stage_pkg::wb_port_t wb;
	logic [data_width-1:0]   write_reg_data;
	logic [data_width-1:0]   write_ra_data;
	logic                    do_kernel_mode;
	logic [data_width-1:0]   reg_ra_data;
	logic [data_width-1:0]   reg_rb_data;
	logic [data_width-1:0]   reg_rt_data;
	logic [data_width-1:0]   system_reg;
	logic                    do_hazard;

	logic [data_width-1:0]   gpr_m [32];
	logic [data_width-1:0]   banked_m;
	logic                    mode_m;
	logic [data_width-1:0]   ra_m;
	logic [data_width-1:0]   rb_m;
	logic [data_width-1:0]   rt_m;
	logic [data_width-1:0]   sysreg_m;
	logic [2:0]              mtsr_pipe_m; // Bit 2 is the mode write at stage 4
	int                      hazard_m;
	string                   test_name;

	reg_stage_top #(
		.data_width (data_width)
	) u_reg_stage_top (
		.clock            (clock),
		.reset            (reset),
		.instr            (instr),
		.instr_valid      (instr_valid),
		.enable_reg_fetch (enable_reg_fetch),
		.enable_reg_write (enable_reg_write),
		.wb               (wb),
		.write_reg_data   (write_reg_data),
		.write_ra_data    (write_ra_data),
		.do_kernel_mode   (do_kernel_mode),
		.reg_ra_data      (reg_ra_data),
		.reg_rb_data      (reg_rb_data),
		.reg_rt_data      (reg_rt_data),
		.system_reg       (system_reg),
		.do_hazard        (do_hazard)
	);

	initial begin
		forever #(clock_period / 2) clock = ~clock;
	end

	initial begin
		#((test_cycles + margin_cycles) * clock_period);
		$display("Timeout: the test sequence ran past its cycle budget");
		$display("Simulation FAILED");
		$fatal(1);
	end

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_outputs();
		check_value("reg_ra_data", ra_m, reg_ra_data);
		check_value("reg_rb_data", rb_m, reg_rb_data);
		check_value("reg_rt_data", rt_m, reg_rt_data);
		check_value("system_reg", sysreg_m, system_reg);
		check_value("do_hazard", hazard_m != 0, do_hazard);
	endtask

	function automatic reg_stage_pkg::instr_t operand_instr(input reg_stage_pkg::reg_addr_t ra,
			input reg_stage_pkg::reg_addr_t rb, input reg_stage_pkg::reg_addr_t rt);
		reg_stage_pkg::instr_t word;
		word = '0;
		word.operand_form.opcode = 6'h01; // Any opcode but misc
		word.operand_form.ra     = ra;
		word.operand_form.rb     = rb;
		word.operand_form.rt     = rt;
		return word;
	endfunction

	function automatic reg_stage_pkg::instr_t misc_instr(input reg_stage_pkg::misc_sel_t sel,
			input reg_stage_pkg::sridx_t idx);
		reg_stage_pkg::instr_t word;
		word = '0;
		word.misc_form.opcode = reg_stage_pkg::opcode_misc;
		word.misc_form.sridx  = idx;
		word.misc_form.select = sel;
		return word;
	endfunction

	task automatic idle_inputs();
		instr            = '0;
		instr_valid      = 1'b0;
		enable_reg_fetch = 1'b0;
		enable_reg_write = 1'b0;
		wb               = '0;
		write_reg_data   = '0;
		write_ra_data    = '0;
		do_kernel_mode   = 1'b0;
	endtask

	// Applies the inputs of the current cycle to the model as of the next edge
	task automatic update_model();
		logic                  is_misc;
		logic                  sr_hit;
		logic [data_width-1:0] sr_value;
		logic [data_width-1:0] old_r31;
		logic                  new_mode;
		logic                  mtsr_now;
		is_misc = instr_valid && instr.misc_form.opcode == reg_stage_pkg::opcode_misc;
		old_r31 = gpr_m[31];
		sr_hit  = 1'b1;
		if (instr.misc_form.sridx == reg_stage_pkg::sridx_system_mode) begin
			sr_value = {{(data_width-1){1'b0}}, mode_m};
		end else if (instr.misc_form.sridx == reg_stage_pkg::sridx_kernel_stack) begin
			sr_value = (mode_m == reg_stage_pkg::mode_kernel) ? gpr_m[31] : banked_m;
		end else if (instr.misc_form.sridx == reg_stage_pkg::sridx_user_stack) begin
			sr_value = (mode_m == reg_stage_pkg::mode_user) ? gpr_m[31] : banked_m;
		end else begin
			sr_hit   = 1'b0;
			sr_value = sysreg_m;
		end
		if (is_misc && instr.misc_form.select == reg_stage_pkg::misc_mfsr && sr_hit) begin
			sysreg_m = sr_value;
		end
		if (enable_reg_fetch) begin
			ra_m = gpr_m[instr.operand_form.ra];
			rb_m = gpr_m[instr.operand_form.rb];
			rt_m = gpr_m[instr.operand_form.rt];
		end
		if (enable_reg_write && wb.do_reg_write) begin
			gpr_m[wb.write_reg_addr] = write_reg_data;
		end
		if (enable_reg_write && wb.do_ra_write) begin
			gpr_m[wb.write_ra_addr] = write_ra_data;
		end
		new_mode = mode_m;
		if (do_kernel_mode) begin
			new_mode = reg_stage_pkg::mode_kernel;
		end else if (mtsr_pipe_m[2]) begin
			new_mode = write_reg_data[0];
		end
		if (new_mode != mode_m) begin
			gpr_m[31] = banked_m;
			banked_m  = old_r31;
		end
		mode_m      = new_mode;
		mtsr_now    = is_misc && instr.misc_form.select == reg_stage_pkg::misc_mtsr;
		mtsr_pipe_m = {mtsr_pipe_m[1:0],
			mtsr_now && instr.misc_form.sridx == reg_stage_pkg::sridx_system_mode};
		if (mtsr_now) begin
			hazard_m = 3;
		end else if (hazard_m > 0) begin
			hazard_m--;
		end
	endtask

	task automatic run_cycle();
		update_model();
		@(posedge clock);
		@(negedge clock);
		check_outputs();
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		idle_inputs();
		repeat (3) @(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < 32; i++) begin
			gpr_m[i] = '0;
		end
		banked_m    = '0;
		mode_m      = reg_stage_pkg::mode_kernel;
		ra_m        = '0;
		rb_m        = '0;
		rt_m        = '0;
		sysreg_m    = '0;
		mtsr_pipe_m = '0;
		hazard_m    = 0;
		check_outputs();
	endtask

	task automatic write_r31(input logic [data_width-1:0] data);
		enable_reg_write  = 1'b1;
		wb                = '0;
		wb.do_reg_write   = 1'b1;
		wb.write_reg_addr = 5'd31;
		write_reg_data    = data;
		run_cycle();
		idle_inputs();
	endtask

	task automatic fetch_r31();
		instr            = operand_instr(5'd31, 5'd0, 5'd0);
		instr_valid      = 1'b1;
		enable_reg_fetch = 1'b1;
		run_cycle();
		idle_inputs();
	endtask

	task automatic read_sysreg(input reg_stage_pkg::sridx_t idx);
		instr       = misc_instr(reg_stage_pkg::misc_mfsr, idx);
		instr_valid = 1'b1;
		run_cycle();
		idle_inputs();
	endtask

	// Misc word on the bus while instr_valid stays low
	task automatic present_without_valid(input reg_stage_pkg::misc_sel_t sel,
			input reg_stage_pkg::sridx_t idx);
		instr       = misc_instr(sel, idx);
		instr_valid = 1'b0;
		run_cycle();
		idle_inputs();
	endtask

	// MTSR in t with the new mode value and an optional pulse in t+3
	task automatic move_to_mode(input logic new_mode, input logic pulse);
		int high_cycles;
		instr       = misc_instr(reg_stage_pkg::misc_mtsr, reg_stage_pkg::sridx_system_mode);
		instr_valid = 1'b1;
		run_cycle();
		idle_inputs();
		high_cycles = int'(do_hazard);
		run_cycle();
		high_cycles += int'(do_hazard);
		run_cycle();
		high_cycles += int'(do_hazard);
		write_reg_data    = $urandom;
		write_reg_data[0] = new_mode;
		do_kernel_mode    = pulse;
		run_cycle();
		idle_inputs();
		check_value("hazard cycles", 3, high_cycles);
		check_value("do_hazard after stall", 0, do_hazard);
	endtask

	task automatic write_then_fetch();
		reg_stage_pkg::reg_addr_t same_addr;
		logic [data_width-1:0]    ra_value;
		test_name = "write_then_fetch";
		for (int i = 0; i < 24; i++) begin
			instr             = operand_instr(5'($urandom), 5'($urandom), 5'($urandom));
			instr_valid       = 1'b1;
			enable_reg_fetch  = 1'b1;
			enable_reg_write  = i < 16; // Writes stop for the last cycles
			wb.do_reg_write   = 1'($urandom);
			wb.write_reg_addr = 5'($urandom);
			wb.do_ra_write    = 1'($urandom);
			wb.write_ra_addr  = 5'($urandom);
			write_reg_data    = $urandom;
			write_ra_data     = $urandom;
			run_cycle();
		end
		same_addr         = 5'($urandom_range(30, 1));
		ra_value          = $urandom;
		enable_reg_write  = 1'b1;
		wb.do_reg_write   = 1'b1;
		wb.write_reg_addr = same_addr;
		wb.do_ra_write    = 1'b1;
		wb.write_ra_addr  = same_addr;
		write_reg_data    = ~ra_value;
		write_ra_data     = ra_value;
		run_cycle();
		idle_inputs();
		instr            = operand_instr(same_addr, same_addr, 5'd0);
		instr_valid      = 1'b1;
		enable_reg_fetch = 1'b1;
		run_cycle();
		idle_inputs();
		check_value("same address write", ra_value, reg_ra_data);
	endtask

	task automatic reset_and_mfsr();
		apply_reset();
		test_name = "reset_and_mfsr";
		read_sysreg(reg_stage_pkg::sridx_system_mode);
		write_r31($urandom);
		read_sysreg(reg_stage_pkg::sridx_kernel_stack);
		present_without_valid(reg_stage_pkg::misc_mfsr, reg_stage_pkg::sridx_system_mode);
		present_without_valid(reg_stage_pkg::misc_mtsr, reg_stage_pkg::sridx_system_mode);
		read_sysreg(10'd5); // Not a system register
		check_value("unknown sridx", gpr_m[31], system_reg);
		read_sysreg(reg_stage_pkg::sridx_user_stack);
	endtask

	task automatic mtsr_to_user();
		logic [data_width-1:0] old_r31;
		logic [data_width-1:0] old_banked;
		test_name = "mtsr_to_user";
		write_r31($urandom);
		old_r31    = gpr_m[31];
		old_banked = banked_m;
		move_to_mode(reg_stage_pkg::mode_user, 1'b0);
		fetch_r31();
		check_value("r31 after switch", old_banked, reg_ra_data);
		read_sysreg(reg_stage_pkg::sridx_kernel_stack);
		check_value("kernel stack", old_r31, system_reg);
		read_sysreg(reg_stage_pkg::sridx_system_mode);
		write_r31($urandom); // User stack pointer
	endtask

	task automatic kernel_entry();
		logic [data_width-1:0] user_sp;
		logic [data_width-1:0] kernel_sp;
		test_name = "kernel_entry";
		user_sp        = gpr_m[31];
		kernel_sp      = banked_m;
		do_kernel_mode = 1'b1;
		run_cycle();
		idle_inputs();
		fetch_r31();
		check_value("r31 after entry", kernel_sp, reg_ra_data);
		read_sysreg(reg_stage_pkg::sridx_user_stack);
		check_value("user stack", user_sp, system_reg);
		do_kernel_mode = 1'b1; // Kernel mode already so r31 stays
		run_cycle();
		idle_inputs();
		fetch_r31();
		test_name = "pulse_over_mtsr";
		move_to_mode(reg_stage_pkg::mode_user, 1'b1);
		read_sysreg(reg_stage_pkg::sridx_system_mode);
		check_value("mode", reg_stage_pkg::mode_kernel, system_reg);
		fetch_r31();
		test_name = "mtsr_round_trip";
		move_to_mode(reg_stage_pkg::mode_user, 1'b0);
		move_to_mode(reg_stage_pkg::mode_kernel, 1'b0);
		read_sysreg(reg_stage_pkg::sridx_system_mode);
		fetch_r31();
	endtask

	initial begin
		void'($urandom(32'h4055357d));
		test_name = "reset";
		apply_reset();
		write_then_fetch();
		reset_and_mfsr();
		mtsr_to_user();
		kernel_entry();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: hdl/reg_stage_top.sv
module reg_stage_top #(
	parameter int data_width = 32
) (
	input  logic                    clock,
	input  logic                    reset,
	input  reg_stage_pkg::instr_t   instr,
	input  logic                    instr_valid,
	input  logic                    enable_reg_fetch,
	input  logic                    enable_reg_write,
	input  reg_stage_pkg::wb_port_t wb,
	input  logic [data_width-1:0]   write_reg_data,
	input  logic [data_width-1:0]   write_ra_data,
	input  logic                    do_kernel_mode,
	output logic [data_width-1:0]   reg_ra_data,
	output logic [data_width-1:0]   reg_rb_data,
	output logic [data_width-1:0]   reg_rt_data,
	output logic [data_width-1:0]   system_reg,
	output logic                    do_hazard
);

	reg_stage_pkg::reg_addr_t rd_addr_ra;
	reg_stage_pkg::reg_addr_t rd_addr_rb;
	reg_stage_pkg::reg_addr_t rd_addr_rt;
	reg_stage_pkg::misc_op_t  dec_op;
	reg_stage_pkg::misc_op_t  x4_op; // Misc op at stage 4

	instr_decoder u_instr_decoder (
		.instr       (instr),
		.instr_valid (instr_valid),
		.rd_addr_ra  (rd_addr_ra),
		.rd_addr_rb  (rd_addr_rb),
		.rd_addr_rt  (rd_addr_rt),
		.dec_op      (dec_op)
	);

	misc_pipe u_misc_pipe (
		.clock     (clock),
		.reset     (reset),
		.dec_op    (dec_op),
		.x4_op     (x4_op),
		.do_hazard (do_hazard)
	);

	regfile #(
		.data_width (data_width)
	) u_regfile (
		.clock            (clock),
		.reset            (reset),
		.enable_reg_fetch (enable_reg_fetch),
		.enable_reg_write (enable_reg_write),
		.rd_addr_ra       (rd_addr_ra),
		.rd_addr_rb       (rd_addr_rb),
		.rd_addr_rt       (rd_addr_rt),
		.wb               (wb),
		.write_reg_data   (write_reg_data),
		.write_ra_data    (write_ra_data),
		.dec_op           (dec_op),
		.x4_op            (x4_op),
		.do_kernel_mode   (do_kernel_mode),
		.reg_ra_data      (reg_ra_data),
		.reg_rb_data      (reg_rb_data),
		.reg_rt_data      (reg_rt_data),
		.system_reg       (system_reg)
	);

endmodule

// File: regfile/regfile.sv
module regfile #(
	parameter int data_width = 32
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     enable_reg_fetch,
	input  logic                     enable_reg_write,
	input  reg_stage_pkg::reg_addr_t rd_addr_ra,
	input  reg_stage_pkg::reg_addr_t rd_addr_rb,
	input  reg_stage_pkg::reg_addr_t rd_addr_rt,
	input  reg_stage_pkg::wb_port_t  wb,
	input  logic [data_width-1:0]    write_reg_data,
	input  logic [data_width-1:0]    write_ra_data,
	input  reg_stage_pkg::misc_op_t  dec_op,
	input  reg_stage_pkg::misc_op_t  x4_op,
	input  logic                     do_kernel_mode,
	output logic [data_width-1:0]    reg_ra_data,
	output logic [data_width-1:0]    reg_rb_data,
	output logic [data_width-1:0]    reg_rt_data,
	output logic [data_width-1:0]    system_reg
);

	logic [data_width-1:0] gpr [32];
	logic [data_width-1:0] r31_banked; // Stack pointer of the inactive mode
	logic                  system_mode;

	logic                  do_mfsr;
	logic                  mfsr_hit;
	logic [data_width-1:0] mfsr_value;
	logic                  mtsr_mode;
	logic                  next_mode;
	logic                  swap_stack;

	assign do_mfsr = dec_op.do_misc && (dec_op.select_misc == reg_stage_pkg::misc_mfsr);

	always_comb begin
		mfsr_hit   = 1'b0;
		mfsr_value = '0;
		case (dec_op.sridx)
			reg_stage_pkg::sridx_system_mode: begin
				mfsr_hit   = 1'b1;
				mfsr_value = {{(data_width-1){1'b0}}, system_mode};
			end
			reg_stage_pkg::sridx_kernel_stack: begin
				mfsr_hit = 1'b1;
				if (system_mode == reg_stage_pkg::mode_kernel) begin
					mfsr_value = gpr[31];
				end else begin
					mfsr_value = r31_banked;
				end
			end
			reg_stage_pkg::sridx_user_stack: begin
				mfsr_hit = 1'b1;
				if (system_mode == reg_stage_pkg::mode_user) begin
					mfsr_value = gpr[31];
				end else begin
					mfsr_value = r31_banked;
				end
			end
			default: begin
				mfsr_hit = 1'b0; // Unknown index keeps system_reg
			end
		endcase
	end

	assign mtsr_mode = x4_op.do_misc
		&& (x4_op.select_misc == reg_stage_pkg::misc_mtsr)
		&& (x4_op.sridx == reg_stage_pkg::sridx_system_mode);

	// Exception entry overrides a pending mode write
	always_comb begin
		next_mode = system_mode;
		if (do_kernel_mode) begin
			next_mode = reg_stage_pkg::mode_kernel;
		end else if (mtsr_mode) begin
			next_mode = write_reg_data[0];
		end
	end

	assign swap_stack = next_mode != system_mode;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				gpr[i] <= '0;
			end
			r31_banked  <= '0;
			system_mode <= reg_stage_pkg::mode_kernel;
			reg_ra_data <= '0;
			reg_rb_data <= '0;
			reg_rt_data <= '0;
			system_reg  <= '0;
		end else begin
			if (enable_reg_fetch) begin
				reg_ra_data <= gpr[rd_addr_ra];
				reg_rb_data <= gpr[rd_addr_rb];
				reg_rt_data <= gpr[rd_addr_rt];
			end
			if (enable_reg_write && wb.do_reg_write) begin
				gpr[wb.write_reg_addr] <= write_reg_data;
			end
			if (enable_reg_write && wb.do_ra_write) begin
				gpr[wb.write_ra_addr] <= write_ra_data; // ra port wins on same address
			end
			if (do_mfsr && mfsr_hit) begin
				system_reg <= mfsr_value;
			end
			system_mode <= next_mode;
			if (swap_stack) begin
				gpr[31]    <= r31_banked;
				r31_banked <= gpr[31];
			end
		end
	end

endmodule

// File: hdl/misc_pipe.sv
module misc_pipe (
	input  logic                    clock,
	input  logic                    reset,
	input  reg_stage_pkg::misc_op_t dec_op,
	output reg_stage_pkg::misc_op_t x4_op,
	output logic                    do_hazard
);

	localparam int depth = 3;

	reg_stage_pkg::misc_op_t stage [depth];
	logic [1:0]              hazard_count;
	logic                    mtsr_entry;

	// Stage 2 to stage 4, one op per cycle
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < depth; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0] <= dec_op;
			for (int i = 1; i < depth; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	assign x4_op = stage[depth-1];

	assign mtsr_entry = dec_op.do_misc && (dec_op.select_misc == reg_stage_pkg::misc_mtsr);

	// Front end holds until the write has reached stage 4
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			hazard_count <= 2'd0;
		end else if (mtsr_entry) begin
			hazard_count <= 2'd3;
		end else if (hazard_count != 2'd0) begin
			hazard_count <= hazard_count - 2'd1;
		end
	end

	assign do_hazard = hazard_count != 2'd0;

endmodule

// File: hdl/instr_decoder.sv
module instr_decoder (
	input  reg_stage_pkg::instr_t    instr,
	input  logic                     instr_valid,
	output reg_stage_pkg::reg_addr_t rd_addr_ra,
	output reg_stage_pkg::reg_addr_t rd_addr_rb,
	output reg_stage_pkg::reg_addr_t rd_addr_rt,
	output reg_stage_pkg::misc_op_t  dec_op
);

	logic                    is_misc;
	logic                    select_known;
	reg_stage_pkg::misc_sel_t select;

	// Operand view, addresses are fetched regardless of opcode
	assign rd_addr_ra = instr.operand_form.ra;
	assign rd_addr_rb = instr.operand_form.rb;
	assign rd_addr_rt = instr.operand_form.rt;

	assign is_misc = instr.misc_form.opcode == reg_stage_pkg::opcode_misc;
	assign select  = instr.misc_form.select;

	always_comb begin
		select_known = 1'b0;
		case (select)
			reg_stage_pkg::misc_mfsr: begin
				select_known = 1'b1;
			end
			reg_stage_pkg::misc_mtsr: begin
				select_known = 1'b1;
			end
			default: begin
				select_known = 1'b0; // Other misc codes are ignored here
			end
		endcase
	end

	// Misc view
	always_comb begin
		dec_op.do_misc     = instr_valid && is_misc && select_known;
		dec_op.select_misc = select;
		dec_op.sridx       = instr.misc_form.sridx;
	end

endmodule

// File: common/reg_stage_pkg.sv
package reg_stage_pkg;

	typedef logic [4:0] reg_addr_t;
	typedef logic [9:0] sridx_t;
	typedef logic [1:0] misc_sel_t;

	// Misc selector codes, 0 and 3 are not decoded
	localparam misc_sel_t misc_mfsr = 2'd1;
	localparam misc_sel_t misc_mtsr = 2'd2;

	localparam sridx_t sridx_system_mode  = 10'd128;
	localparam sridx_t sridx_kernel_stack = 10'd178;
	localparam sridx_t sridx_user_stack   = 10'd186;

	localparam logic mode_kernel = 1'b0;
	localparam logic mode_user   = 1'b1;

	localparam logic [5:0] opcode_misc = 6'b110010;

	// Register operand layout
	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t  rt;
		reg_addr_t  ra;
		reg_addr_t  rb;
		logic [4:0] shamt; // Not used by this stage
		logic [5:0] func;
	} operand_form_t;

	// System register move layout
	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t  rt;
		sridx_t     sridx;
		logic [8:0] spare;
		misc_sel_t  select;
	} misc_form_t;

	typedef union packed {
		operand_form_t operand_form;
		misc_form_t    misc_form;
	} instr_t;

	typedef struct packed {
		logic      do_misc;
		misc_sel_t select_misc;
		sridx_t    sridx;
	} misc_op_t;

	typedef struct packed {
		logic      do_reg_write;
		reg_addr_t write_reg_addr;
		logic      do_ra_write;
		reg_addr_t write_ra_addr;
	} wb_port_t;

endpackage
